/* run.sh */
#!/bin/sh
# Build the CPU testbench with Verilator and run it
# The exit status is nonzero when the testbench stops on an error

cd "$(dirname "$0")" &&
verilator --binary --assert \
    --top-module tbCpu \
    -f sim.f \
    -o tbCpuSim &&
./obj_dir/tbCpuSim ||
{ echo "Simulation did not pass"; exit 1; }

/* sim.f */
+incdir+tb
src/cpuPkg.sv
src/stageIf.sv
src/instrMem.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/writebackStage.sv
src/cpuTop.sv
tb/tbCpu.sv

/* src/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int numRegs = 16;
    localparam int regAddrWidth = 4;

    // Instruction field positions
    localparam int opLsb = 27;
    localparam int raLsb = 23;
    localparam int rbLsb = 19;      // Branch condition sits here too
    localparam int rcLsb = 15;
    localparam int constWidth = 19;

    typedef enum logic [4:0] {
        opLdi, opAddi, opAdd, opSub, opAnd, opOr, opIn, opOut, opBr, opHalt
    } cpuOp;

    typedef enum logic [1:0] {
        condZr, condNz, condPl, condMi
    } brCond;

    // Four-phase sender and receiver states
    typedef enum logic [1:0] {
        xIdle, xReq, xWaitAckLow, xAck
    } xferState;

    typedef struct packed {
        cpuOp op;
        logic [regAddrWidth-1:0] dest;
        logic wrFlag;
        logic [dataWidth-1:0] opA;      // Holds the result after execute
        logic [dataWidth-1:0] opB;
        brCond cond;
        logic [dataWidth-1:0] pcNext;
    } decodedOp;

endpackage

`default_nettype wire

/* src/cpuTop.sv */
`default_nettype none

module cpuTop #(
    parameter int imemDepth = 64,
    localparam int addrWidth = $clog2(imemDepth)
) (
    input  logic clk,
    input  logic rst,
    input  logic progReq,
    input  logic [addrWidth-1:0] progAddr,
    input  logic [31:0] progData,
    output logic progAck,
    input  logic start,
    input  logic [31:0] inData,
    output logic outReq,
    output logic [31:0] outData,
    input  logic outAck,
    output logic halted
);
    localparam int opWidth = $bits(cpuPkg::decodedOp);

    logic [addrWidth-1:0] rdAddr;
    logic [31:0] rdData;
    logic redirect;
    logic taken;
    logic [31:0] target;
    logic wrEn;
    logic [3:0] wrAddr;
    logic [31:0] wrData;

    stageIf #(.payloadWidth(64)) fetchToDecode ();          // Word and PC
    stageIf #(.payloadWidth(opWidth)) decodeToExecute ();
    stageIf #(.payloadWidth(opWidth)) executeToWriteback ();

    instrMem #(.imemDepth(imemDepth)) i_instrMem (
        .clk      (clk),
        .rst      (rst),
        .progReq  (progReq),
        .progAddr (progAddr),
        .progData (progData),
        .progAck  (progAck),
        .rdAddr   (rdAddr),
        .rdData   (rdData)
    );

    fetchStage #(.imemDepth(imemDepth)) i_fetchStage (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .halted   (halted),
        .redirect (redirect),
        .taken    (taken),
        .target   (target),
        .rdAddr   (rdAddr),
        .rdData   (rdData),
        .toDecode (fetchToDecode)
    );

    decodeStage i_decodeStage (
        .clk       (clk),
        .rst       (rst),
        .fromFetch (fetchToDecode),
        .toExecute (decodeToExecute),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData)
    );

    executeStage i_executeStage (
        .clk         (clk),
        .rst         (rst),
        .fromDecode  (decodeToExecute),
        .toWriteback (executeToWriteback),
        .inData      (inData),
        .redirect    (redirect),
        .taken       (taken),
        .target      (target)
    );

    writebackStage i_writebackStage (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .fromExecute (executeToWriteback),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .outReq      (outReq),
        .outData     (outData),
        .outAck      (outAck),
        .halted      (halted)
    );

endmodule

`default_nettype wire

/* src/decodeStage.sv */
`default_nettype none

module decodeStage (
    input  logic clk,
    input  logic rst,
    stageIf.sink fromFetch,
    stageIf.source toExecute,
    input  logic wrEn,
    input  logic [3:0] wrAddr,
    input  logic [31:0] wrData
);
    logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::numRegs];
    logic [cpuPkg::numRegs-1:0] pending;   // Scoreboard of writes in flight
    logic [31:0] instr;
    logic [31:0] instrPc;
    cpuPkg::cpuOp op;
    logic [cpuPkg::regAddrWidth-1:0] ra;
    logic [cpuPkg::regAddrWidth-1:0] rb;
    logic [cpuPkg::regAddrWidth-1:0] rc;
    logic [cpuPkg::dataWidth-1:0] constExt;
    logic readsA;
    logic readsB;
    logic readsC;
    logic writesA;
    logic hazard;
    logic accept;
    cpuPkg::decodedOp nextItem;
    cpuPkg::xferState sendState;

    assign instr = fromFetch.payload[63:32];
    assign instrPc = fromFetch.payload[31:0];
    assign op = cpuPkg::cpuOp'(instr[cpuPkg::opLsb +: 5]);
    assign ra = instr[cpuPkg::raLsb +: cpuPkg::regAddrWidth];
    assign rb = instr[cpuPkg::rbLsb +: cpuPkg::regAddrWidth];
    assign rc = instr[cpuPkg::rcLsb +: cpuPkg::regAddrWidth];
    assign constExt = {{(cpuPkg::dataWidth - cpuPkg::constWidth){instr[cpuPkg::constWidth-1]}},
                       instr[cpuPkg::constWidth-1:0]};

    always_comb begin
        readsA = 1'b0;
        readsB = 1'b0;
        readsC = 1'b0;
        writesA = 1'b0;
        case (op)
            cpuPkg::opLdi, cpuPkg::opIn: writesA = 1'b1;
            cpuPkg::opAddi: begin
                readsB = 1'b1;
                writesA = 1'b1;
            end
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr: begin
                readsB = 1'b1;
                readsC = 1'b1;
                writesA = 1'b1;
            end
            cpuPkg::opOut, cpuPkg::opBr: readsA = 1'b1;
            default: ;
        endcase
    end

    // Destination counts too, so two writes to one register never overlap
    assign hazard = ((readsA || writesA) && pending[ra]) ||
                    (readsB && pending[rb]) ||
                    (readsC && pending[rc]);
    assign accept = fromFetch.req && !fromFetch.ack && !hazard &&
                    sendState == cpuPkg::xIdle;

    always_comb begin
        nextItem.op = op;
        nextItem.dest = ra;
        nextItem.wrFlag = writesA;
        nextItem.opA = readsA ? regs[ra] : regs[rb];
        nextItem.opB = readsC ? regs[rc] : constExt;
        nextItem.cond = cpuPkg::brCond'(instr[cpuPkg::rbLsb +: 2]);
        nextItem.pcNext = instrPc + 32'd1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            fromFetch.ack <= 1'b0;
            toExecute.req <= 1'b0;
            sendState <= cpuPkg::xIdle;
        end else begin
            if (wrEn) begin
                pending[wrAddr] <= 1'b0;
            end
            if (accept && writesA) begin
                pending[ra] <= 1'b1;
            end
            if (accept) begin
                fromFetch.ack <= 1'b1;
            end else if (fromFetch.ack && !fromFetch.req) begin
                fromFetch.ack <= 1'b0;
            end
            case (sendState)
                cpuPkg::xIdle: begin
                    if (accept) begin
                        toExecute.req <= 1'b1;
                        sendState <= cpuPkg::xReq;
                    end
                end
                cpuPkg::xReq: begin
                    if (toExecute.ack) begin
                        toExecute.req <= 1'b0;
                        sendState <= cpuPkg::xWaitAckLow;
                    end
                end
                cpuPkg::xWaitAckLow: begin
                    if (!toExecute.ack) begin
                        sendState <= cpuPkg::xIdle;
                    end
                end
                default: sendState <= cpuPkg::xIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
        if (accept) begin
            toExecute.payload <= nextItem;
        end
    end

    // Every retiring write was booked here when it left decode
    assert property (@(posedge clk) disable iff (rst) wrEn |-> pending[wrAddr]);

    assert property (@(posedge clk) disable iff (rst)
        toExecute.req && $past(toExecute.req) |-> $stable(toExecute.payload));

endmodule

`default_nettype wire

/* src/executeStage.sv */
`default_nettype none

module executeStage (
    input  logic clk,
    input  logic rst,
    stageIf.sink fromDecode,
    stageIf.source toWriteback,
    input  logic [31:0] inData,
    output logic redirect,
    output logic taken,
    output logic [31:0] target
);
    cpuPkg::decodedOp item;
    cpuPkg::decodedOp outItem;
    logic [31:0] result;
    logic condTrue;
    logic isBranch;
    logic accept;
    cpuPkg::xferState sendState;

    assign item = fromDecode.payload;
    assign isBranch = item.op == cpuPkg::opBr;
    // Branches end here, so they never wait for the writeback sender
    assign accept = fromDecode.req && !fromDecode.ack &&
                    (sendState == cpuPkg::xIdle || isBranch);

    always_comb begin
        case (item.op)
            cpuPkg::opLdi: result = item.opB;
            cpuPkg::opAddi, cpuPkg::opAdd: result = item.opA + item.opB;
            cpuPkg::opSub: result = item.opA - item.opB;
            cpuPkg::opAnd: result = item.opA & item.opB;
            cpuPkg::opOr: result = item.opA | item.opB;
            cpuPkg::opIn: result = inData;
            default: result = item.opA;     // opOut carries Ra
        endcase
    end

    always_comb begin
        case (item.cond)
            cpuPkg::condZr: condTrue = item.opA == '0;
            cpuPkg::condNz: condTrue = item.opA != '0;
            cpuPkg::condPl: condTrue = !item.opA[31];
            default: condTrue = item.opA[31];
        endcase
    end

    always_comb begin
        outItem = item;
        outItem.opA = result;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fromDecode.ack <= 1'b0;
            toWriteback.req <= 1'b0;
            sendState <= cpuPkg::xIdle;
            redirect <= 1'b0;
        end else begin
            redirect <= accept && isBranch;
            if (accept) begin
                fromDecode.ack <= 1'b1;
            end else if (fromDecode.ack && !fromDecode.req) begin
                fromDecode.ack <= 1'b0;
            end
            case (sendState)
                cpuPkg::xIdle: begin
                    if (accept && !isBranch) begin
                        toWriteback.req <= 1'b1;
                        sendState <= cpuPkg::xReq;
                    end
                end
                cpuPkg::xReq: begin
                    if (toWriteback.ack) begin
                        toWriteback.req <= 1'b0;
                        sendState <= cpuPkg::xWaitAckLow;
                    end
                end
                cpuPkg::xWaitAckLow: begin
                    if (!toWriteback.ack) begin
                        sendState <= cpuPkg::xIdle;
                    end
                end
                default: sendState <= cpuPkg::xIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && isBranch) begin
            taken <= condTrue;
            target <= item.pcNext + item.opB;   // PC + 1 + sext(C)
        end else if (accept) begin
            toWriteback.payload <= outItem;
        end
    end

    // Decode withdraws an item only once it was taken
    assert property (@(posedge clk) disable iff (rst) $fell(fromDecode.req) |-> fromDecode.ack);

    assert property (@(posedge clk) disable iff (rst)
        toWriteback.req && $past(toWriteback.req) |-> $stable(toWriteback.payload));

endmodule

`default_nettype wire

/* src/fetchStage.sv */
`default_nettype none

module fetchStage #(
    parameter int imemDepth = 64,
    localparam int addrWidth = $clog2(imemDepth)
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic halted,
    input  logic redirect,
    input  logic taken,
    input  logic [31:0] target,
    output logic [addrWidth-1:0] rdAddr,
    input  logic [31:0] rdData,
    stageIf.source toDecode
);
    logic [31:0] pc;
    logic [31:0] pcNext;
    logic running;
    logic waitBranch;
    logic issue;
    cpuPkg::cpuOp fetchedOp;
    cpuPkg::xferState sendState;

    assign fetchedOp = cpuPkg::cpuOp'(rdData[cpuPkg::opLsb +: 5]);
    assign issue = running && !waitBranch && sendState == cpuPkg::xIdle;

    always_comb begin
        pcNext = pc;
        if (start) begin
            pcNext = '0;
        end else if (redirect && taken) begin
            pcNext = target;
        end else if (issue) begin
            pcNext = pc + 32'd1;
        end
    end

    // RAM reads the next PC, so rdData always holds the word at pc
    assign rdAddr = pcNext[addrWidth-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            running <= 1'b0;
            waitBranch <= 1'b0;
            sendState <= cpuPkg::xIdle;
            toDecode.req <= 1'b0;
        end else begin
            pc <= pcNext;
            if (start) begin
                running <= 1'b1;
                waitBranch <= 1'b0;
            end else if (halted) begin
                running <= 1'b0;
            end
            if (redirect) begin
                waitBranch <= 1'b0;
            end
            case (sendState)
                cpuPkg::xIdle: begin
                    if (issue) begin
                        toDecode.req <= 1'b1;
                        sendState <= cpuPkg::xReq;
                        if (fetchedOp == cpuPkg::opBr) begin
                            waitBranch <= 1'b1;     // Hold until execute resolves it
                        end
                        if (fetchedOp == cpuPkg::opHalt) begin
                            running <= 1'b0;
                        end
                    end
                end
                cpuPkg::xReq: begin
                    if (toDecode.ack) begin
                        toDecode.req <= 1'b0;
                        sendState <= cpuPkg::xWaitAckLow;
                    end
                end
                cpuPkg::xWaitAckLow: begin
                    if (!toDecode.ack) begin
                        sendState <= cpuPkg::xIdle;
                    end
                end
                default: sendState <= cpuPkg::xIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            toDecode.payload <= {rdData, pc};
        end
    end

    // Every redirect answers the one branch fetch is holding for
    assert property (@(posedge clk) disable iff (rst) redirect |-> waitBranch);

    assert property (@(posedge clk) disable iff (rst)
        toDecode.req && $past(toDecode.req) |-> $stable(toDecode.payload));

endmodule

`default_nettype wire

/* src/instrMem.sv */
`default_nettype none

module instrMem #(
    parameter int imemDepth = 64,
    localparam int addrWidth = $clog2(imemDepth)
) (
    input  logic clk,
    input  logic rst,
    input  logic progReq,
    input  logic [addrWidth-1:0] progAddr,
    input  logic [31:0] progData,
    output logic progAck,
    input  logic [addrWidth-1:0] rdAddr,
    output logic [31:0] rdData
);
    logic [31:0] mem [imemDepth];
    cpuPkg::xferState loadState;

    // Host load receiver
    always_ff @(posedge clk) begin
        if (rst) begin
            loadState <= cpuPkg::xIdle;
            progAck <= 1'b0;
        end else begin
            case (loadState)
                cpuPkg::xIdle: begin
                    if (progReq) begin
                        progAck <= 1'b1;
                        loadState <= cpuPkg::xAck;
                    end
                end
                cpuPkg::xAck: begin
                    if (!progReq) begin     // Host is done with this word
                        progAck <= 1'b0;
                        loadState <= cpuPkg::xIdle;
                    end
                end
                default: loadState <= cpuPkg::xIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (loadState == cpuPkg::xIdle && progReq) begin
            mem[progAddr] <= progData;
        end
        rdData <= mem[rdAddr];      // One-cycle read
    end

    assert property (@(posedge clk) disable iff (rst)
        progReq && $past(progReq) |-> $stable(progAddr));

endmodule

`default_nettype wire

/* src/stageIf.sv */
`default_nettype none

// One four-phase transfer between two neighbouring stages
interface stageIf #(
    parameter int payloadWidth = 64
);
    logic req;
    logic ack;
    logic [payloadWidth-1:0] payload;

    modport source (output req, output payload, input ack);
    modport sink (input req, input payload, output ack);
endinterface

`default_nettype wire

/* src/writebackStage.sv */
`default_nettype none

module writebackStage (
    input  logic clk,
    input  logic rst,
    input  logic start,
    stageIf.sink fromExecute,
    output logic wrEn,
    output logic [3:0] wrAddr,
    output logic [31:0] wrData,
    output logic outReq,
    output logic [31:0] outData,
    input  logic outAck,
    output logic halted
);
    cpuPkg::decodedOp item;
    cpuPkg::xferState state;
    logic newItem;

    assign item = fromExecute.payload;
    assign newItem = state == cpuPkg::xIdle && fromExecute.req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpuPkg::xIdle;
            fromExecute.ack <= 1'b0;
            wrEn <= 1'b0;
            outReq <= 1'b0;
            halted <= 1'b0;
        end else begin
            wrEn <= 1'b0;
            if (start) begin
                halted <= 1'b0;
            end
            case (state)
                cpuPkg::xIdle: begin
                    if (fromExecute.req && item.op == cpuPkg::opOut) begin
                        outReq <= 1'b1;             // Ack waits for the host
                        state <= cpuPkg::xReq;
                    end else if (fromExecute.req) begin
                        wrEn <= item.wrFlag;
                        if (item.op == cpuPkg::opHalt) begin
                            halted <= 1'b1;
                        end
                        fromExecute.ack <= 1'b1;
                        state <= cpuPkg::xAck;
                    end
                end
                cpuPkg::xReq: begin
                    if (outAck) begin
                        outReq <= 1'b0;
                        state <= cpuPkg::xWaitAckLow;
                    end
                end
                cpuPkg::xWaitAckLow: begin
                    if (!outAck) begin
                        fromExecute.ack <= 1'b1;
                        state <= cpuPkg::xAck;
                    end
                end
                cpuPkg::xAck: begin
                    if (!fromExecute.req) begin
                        fromExecute.ack <= 1'b0;
                        state <= cpuPkg::xIdle;
                    end
                end
                default: state <= cpuPkg::xIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (newItem) begin
            wrAddr <= item.dest;
            wrData <= item.opA;
            outData <= item.opA;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        outReq && $past(outReq) |-> $stable(outData));

    // An out value is fully handed over before execute sees the ack
    assert property (@(posedge clk) disable iff (rst)
        $rose(fromExecute.ack) |-> !outReq && !outAck);

endmodule

`default_nettype wire

/* tb/tbPrograms.svh */
localparam int numProgs = 5;
localparam int maxWords = 96;
localparam int maxOuts = 32;

// Programs and expected out values packed back to back
// with a base and a length per entry
logic [31:0] progWords [maxWords];
logic [31:0] expWords [maxOuts];
logic [31:0] inTable [numProgs];
int progBase [numProgs];
int progLen [numProgs];
int expBase [numProgs];
int expLen [numProgs];
int wordTotal;
int outTotal;
int progTotal;

// Ra = Rb op Rc
function automatic logic [31:0] regInstr(cpuPkg::cpuOp op, int ra, int rb, int rc);
    logic [31:0] w;
    w = '0;
    w[31:27] = op;
    w[26:23] = ra[3:0];
    w[22:19] = rb[3:0];
    w[18:15] = rc[3:0];
    return w;
endfunction

// Ops with the 19-bit constant C
function automatic logic [31:0] constInstr(cpuPkg::cpuOp op, int ra, int rb, int c);
    logic [31:0] w;
    w = '0;
    w[31:27] = op;
    w[26:23] = ra[3:0];
    w[22:19] = rb[3:0];
    w[18:0] = c[18:0];
    return w;
endfunction

function automatic logic [31:0] branchInstr(cpuPkg::brCond cond, int ra, int c);
    logic [31:0] w;
    w = '0;
    w[31:27] = cpuPkg::opBr;
    w[26:23] = ra[3:0];
    w[20:19] = cond;        // Overlaps the rb field
    w[18:0] = c[18:0];
    return w;
endfunction

task automatic addWord(input logic [31:0] w);
    progWords[wordTotal] = w;
    wordTotal++;
endtask

task automatic expectOut(input logic [31:0] v);
    expWords[outTotal] = v;
    outTotal++;
endtask

task automatic openProgram(input logic [31:0] inValue);
    progBase[progTotal] = wordTotal;
    expBase[progTotal] = outTotal;
    inTable[progTotal] = inValue;
endtask

task automatic closeProgram();
    progLen[progTotal] = wordTotal - progBase[progTotal];
    expLen[progTotal] = outTotal - expBase[progTotal];
    progTotal++;
endtask

task automatic buildPrograms();
    wordTotal = 0;
    outTotal = 0;
    progTotal = 0;

    // Arithmetic and constant sign extension
    openProgram(32'h0000_0000);
    addWord(constInstr(cpuPkg::opLdi, 1, 0, 100));
    addWord(constInstr(cpuPkg::opLdi, 2, 0, -7));
    addWord(constInstr(cpuPkg::opAddi, 3, 1, 25));
    addWord(regInstr(cpuPkg::opAdd, 4, 1, 2));
    addWord(regInstr(cpuPkg::opSub, 5, 2, 1));
    addWord(regInstr(cpuPkg::opAnd, 6, 3, 2));
    addWord(regInstr(cpuPkg::opOr, 7, 5, 1));
    addWord(constInstr(cpuPkg::opLdi, 8, 0, 32'h3FFFF));     // Largest positive C
    addWord(constInstr(cpuPkg::opLdi, 9, 0, -262144));       // Most negative C
    addWord(regInstr(cpuPkg::opAdd, 10, 8, 9));
    addWord(constInstr(cpuPkg::opOut, 3, 0, 0));
    addWord(constInstr(cpuPkg::opOut, 4, 0, 0));
    addWord(constInstr(cpuPkg::opOut, 5, 0, 0));
    addWord(constInstr(cpuPkg::opOut, 6, 0, 0));
    addWord(constInstr(cpuPkg::opOut, 7, 0, 0));
    addWord(constInstr(cpuPkg::opOut, 10, 0, 0));
    addWord(constInstr(cpuPkg::opHalt, 0, 0, 0));
    expectOut(32'h0000_007D);   // 100 + 25
    expectOut(32'h0000_005D);   // 100 - 7
    expectOut(32'hFFFF_FF95);   // -7 - 100
    expectOut(32'h0000_0079);   // 0x7D & 0xFFFFFFF9
    expectOut(32'hFFFF_FFF5);   // 0xFFFFFF95 | 0x64
    expectOut(32'hFFFF_FFFF);   // 0x3FFFF + 0xFFFC0000
    closeProgram();

    // Back-to-back dependent writes that stall on the scoreboard
    openProgram(32'h1234_5678);
    addWord(constInstr(cpuPkg::opLdi, 1, 0, 5));
    addWord(constInstr(cpuPkg::opAddi, 1, 1, 3));
    addWord(regInstr(cpuPkg::opAdd, 1, 1, 1));
    addWord(constInstr(cpuPkg::opAddi, 2, 1, -20));
    addWord(constInstr(cpuPkg::opOut, 1, 0, 0));
    addWord(constInstr(cpuPkg::opOut, 2, 0, 0));
    addWord(constInstr(cpuPkg::opLdi, 3, 0, -1));
    addWord(constInstr(cpuPkg::opAddi, 3, 3, 1));           // Wraps to zero
    addWord(constInstr(cpuPkg::opOut, 3, 0, 0));
    addWord(regInstr(cpuPkg::opSub, 4, 3, 1));
    addWord(constInstr(cpuPkg::opOut, 4, 0, 0));
    addWord(constInstr(cpuPkg::opHalt, 0, 0, 0));
    expectOut(32'h0000_0010);
    expectOut(32'hFFFF_FFFC);
    expectOut(32'h0000_0000);
    expectOut(32'hFFFF_FFF0);
    closeProgram();

    // Every condition taken and not taken with r15 marking a wrong path
    openProgram(32'h0000_0000);
    addWord(constInstr(cpuPkg::opLdi, 1, 0, 0));
    addWord(constInstr(cpuPkg::opLdi, 2, 0, -3));
    addWord(constInstr(cpuPkg::opLdi, 3, 0, 9));
    addWord(constInstr(cpuPkg::opLdi, 15, 0, 32'hBAD));
    addWord(branchInstr(cpuPkg::condZr, 3, 1));     // Not taken
    addWord(constInstr(cpuPkg::opOut, 3, 0, 0));
    addWord(branchInstr(cpuPkg::condZr, 1, 1));     // Taken
    addWord(constInstr(cpuPkg::opOut, 15, 0, 0));
    addWord(branchInstr(cpuPkg::condNz, 1, 1));
    addWord(constInstr(cpuPkg::opOut, 1, 0, 0));
    addWord(branchInstr(cpuPkg::condNz, 3, 1));
    addWord(constInstr(cpuPkg::opOut, 15, 0, 0));
    addWord(branchInstr(cpuPkg::condPl, 2, 1));
    addWord(constInstr(cpuPkg::opOut, 2, 0, 0));
    addWord(branchInstr(cpuPkg::condPl, 3, 1));
    addWord(constInstr(cpuPkg::opOut, 15, 0, 0));
    addWord(branchInstr(cpuPkg::condMi, 3, 1));
    addWord(constInstr(cpuPkg::opOut, 3, 0, 0));
    addWord(constInstr(cpuPkg::opAddi, 2, 2, 1));   // Loop head at 18
    addWord(constInstr(cpuPkg::opOut, 2, 0, 0));
    addWord(branchInstr(cpuPkg::condMi, 2, -3));    // 21 - 3 = 18
    addWord(constInstr(cpuPkg::opHalt, 0, 0, 0));
    expectOut(32'h0000_0009);
    expectOut(32'h0000_0000);
    expectOut(32'hFFFF_FFFD);
    expectOut(32'h0000_0009);
    expectOut(32'hFFFF_FFFE);
    expectOut(32'hFFFF_FFFF);
    expectOut(32'h0000_0000);
    closeProgram();

    // Counting loop with a stream of outs
    openProgram(32'h0BAD_F00D);
    addWord(constInstr(cpuPkg::opLdi, 1, 0, 4));
    addWord(constInstr(cpuPkg::opLdi, 2, 0, 32'h100));
    addWord(constInstr(cpuPkg::opOut, 2, 0, 0));
    addWord(constInstr(cpuPkg::opAddi, 2, 2, 32'h10));
    addWord(constInstr(cpuPkg::opAddi, 1, 1, -1));
    addWord(branchInstr(cpuPkg::condNz, 1, -4));    // Back to 2
    addWord(constInstr(cpuPkg::opHalt, 0, 0, 0));
    expectOut(32'h0000_0100);
    expectOut(32'h0000_0110);
    expectOut(32'h0000_0120);
    expectOut(32'h0000_0130);
    closeProgram();

    // Input port
    openProgram(32'hCAFE_1234);
    addWord(constInstr(cpuPkg::opIn, 1, 0, 0));
    addWord(constInstr(cpuPkg::opAddi, 2, 1, 1));
    addWord(constInstr(cpuPkg::opOut, 1, 0, 0));
    addWord(constInstr(cpuPkg::opOut, 2, 0, 0));
    addWord(constInstr(cpuPkg::opHalt, 0, 0, 0));
    expectOut(32'hCAFE_1234);
    expectOut(32'hCAFE_1235);
    closeProgram();
endtask

/* tb/tbCpu.sv */
`default_nettype none

module tbCpu;

    localparam int imemDepth = 64;
    localparam int addrWidth = $clog2(imemDepth);
    localparam int resetCycles = 8;
    localparam int cyclesPerWord = 60;      // Run budget per program word
    localparam int loadCyclesPerWord = 4;
    localparam int maxAckDelay = 5;

    logic clk;
    logic rst;
    logic progReq;
    logic [addrWidth-1:0] progAddr;
    logic [31:0] progData;
    logic progAck;
    logic start;
    logic [31:0] inData;
    logic outReq;
    logic [31:0] outData;
    logic outAck;
    logic halted;

    int cycleCount = 0;
    int timeoutLimit;

    `include "tbPrograms.svh"

    cpuTop #(.imemDepth(imemDepth)) i_cpuTop (
        .clk      (clk),
        .rst      (rst),
        .progReq  (progReq),
        .progAddr (progAddr),
        .progData (progData),
        .progAck  (progAck),
        .start    (start),
        .inData   (inData),
        .outReq   (outReq),
        .outData  (outData),
        .outAck   (outAck),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            stopOnError($sformatf("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h",
                                  $time, name, actual, expected));
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stopOnError($sformatf("[FAIL] t=%0t %s: got %b, expected %b",
                                  $time, name, actual, expected));
        end
    endtask

    // Watchdog against a stuck handshake
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            stopOnError($sformatf("Timeout: run still going after %0d cycles", cycleCount));
        end
    end

    // Inputs change and outputs are read just after the edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    // Host side of the four-phase load port
    task automatic loadWord(input int addr, input logic [31:0] data);
        progAddr = addrWidth'(addr);
        progData = data;
        progReq = 1'b1;
        while (!progAck) stepCycle();
        progReq = 1'b0;
        while (progAck) stepCycle();
    endtask

    task automatic runProgram(input int p);
        int seen;
        int delay;
        start = 1'b1;
        stepCycle();
        start = 1'b0;
        checkFlag("halted", halted, 1'b0);     // Cleared by start
        seen = 0;
        while (!halted) begin
            if (outReq) begin
                if (seen >= expLen[p]) begin
                    stopOnError($sformatf("Program %0d sent more than %0d out values",
                                          p, expLen[p]));
                end
                delay = $urandom_range(maxAckDelay, 0);
                repeat (delay) stepCycle();
                checkWord("outData", outData, expWords[expBase[p] + seen]);
                outAck = 1'b1;
                while (outReq) stepCycle();
                outAck = 1'b0;
                seen++;
            end
            stepCycle();
        end
        if (seen != expLen[p]) begin
            stopOnError($sformatf("Program %0d halted after %0d out values, expected %0d",
                                  p, seen, expLen[p]));
        end
        stepCycle();
        checkFlag("halted", halted, 1'b1);
        checkFlag("outReq", outReq, 1'b0);
    endtask

    initial begin
        rst = 1'b1;
        progReq = 1'b0;
        progAddr = '0;
        progData = '0;
        start = 1'b0;
        inData = '0;
        outAck = 1'b0;
        void'($urandom(75633));
        buildPrograms();
        timeoutLimit = resetCycles + wordTotal * (cyclesPerWord + loadCyclesPerWord);

        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        checkFlag("outReq", outReq, 1'b0);
        checkFlag("halted", halted, 1'b0);
        checkFlag("progAck", progAck, 1'b0);

        for (int p = 0; p < progTotal; p++) begin
            inData = inTable[p];
            for (int w = 0; w < progLen[p]; w++) begin
                loadWord(w, progWords[progBase[p] + w]);
            end
            runProgram(p);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
